/* include/cache_consts.svh */
// Cache geometry, address field widths, LRU age width and counter width
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Associativity of the data cache
`define D_WAYS 8

// Associativity of the instruction cache
`define I_WAYS 4

// Index width, 16 sets per cache
`define SET_BITS 4

// Byte offset inside a line, not used for lookup
`define OFFSET_BITS 6

// Upper address bits left over for the tag
`define TAG_BITS 22

// LRU age, wide enough for the larger cache
`define AGE_BITS 3

// Hit and miss counters
`define CNT_BITS 16

`endif

/* src/cache_cmd_pkg.sv */
// Command opcode enum for the cache tag subsystem
`default_nettype none

package cache_cmd_pkg;

    // Opcodes as they arrive from the bus
    typedef enum logic [3:0] {
        // Data read from the core
        OP_DREAD  = 4'd0,
        // Data write from the core
        OP_DWRITE = 4'd1,
        // Instruction fetch, served by the I side only
        OP_IFETCH = 4'd2,
        // Invalidate request from L2
        OP_INVAL  = 4'd3,
        // Read snooped from another cache
        OP_SNOOP  = 4'd4,
        // Reset every line in both caches
        OP_CLEAR  = 4'd8
    } cache_op_e;

endpackage : cache_cmd_pkg

`default_nettype wire

/* src/cache_line_pkg.sv */
// MESI state enum plus tag and LRU age types for one cache line
`default_nettype none

`include "cache_consts.svh"

package cache_line_pkg;

    // Line coherence state
    typedef enum logic [1:0] {
        // Invalid, holds nothing
        ST_I = 2'd0,
        // Shared, clean and possibly in other caches
        ST_S = 2'd1,
        // Exclusive, clean and only here
        ST_E = 2'd2,
        // Modified, dirty and only here
        ST_M = 2'd3
    } mesi_e;

    // Tag field of a line
    typedef logic [`TAG_BITS-1:0] tag_t;

    // LRU age, 0 is the most recently used way
    typedef logic [`AGE_BITS-1:0] age_t;

endpackage : cache_line_pkg

`default_nettype wire

/* src/cache_array.sv */
// Set storage of one cache with registered read, write, clear and bypass
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_array #(
    parameter int WAYS = 8
) (
    input  wire                                  clk,
    input  wire                                  rst_n_i,
    input  wire                                  rd_en_i,
    input  wire  [`SET_BITS-1:0]                 rd_idx_i,
    input  wire                                  wr_en_i,
    input  wire  [`SET_BITS-1:0]                 wr_idx_i,
    input  wire  cache_line_pkg::tag_t  [WAYS-1:0] wr_tag_i,
    input  wire  cache_line_pkg::mesi_e [WAYS-1:0] wr_state_i,
    input  wire  cache_line_pkg::age_t  [WAYS-1:0] wr_age_i,
    input  wire                                  clr_i,
    output cache_line_pkg::tag_t  [WAYS-1:0]     rd_tag_o,
    output cache_line_pkg::mesi_e [WAYS-1:0]     rd_state_o,
    output cache_line_pkg::age_t  [WAYS-1:0]     rd_age_o
);
    import cache_line_pkg::*;

    localparam int SETS = 1 << `SET_BITS;

    // One entry per set, all ways side by side
    tag_t  [WAYS-1:0] tag_mem   [SETS];
    mesi_e [WAYS-1:0] state_mem [SETS];
    age_t  [WAYS-1:0] age_mem   [SETS];

    // Pattern after reset or clear
    age_t  [WAYS-1:0] init_age;
    mesi_e [WAYS-1:0] init_state;

    // Read data after forwarding
    tag_t  [WAYS-1:0] fwd_tag;
    mesi_e [WAYS-1:0] fwd_state;
    age_t  [WAYS-1:0] fwd_age;
    logic             wr_match;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            // Age equals way number, so ages start as a permutation
            init_age[w]   = age_t'(w);
            init_state[w] = ST_I;
        end
    end

    // Tags keep their content, the state alone marks a line empty
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_idx_i] <= wr_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || clr_i) begin
            for (int s = 0; s < SETS; s++) begin
                state_mem[s] <= init_state;
                age_mem[s]   <= init_age;
            end
        end else if (wr_en_i) begin
            state_mem[wr_idx_i] <= wr_state_i;
            age_mem[wr_idx_i]   <= wr_age_i;
        end
    end

    // A write in the same cycle wins over the stored set
    assign wr_match = wr_en_i && (wr_idx_i == rd_idx_i);

    always_comb begin
        fwd_tag   = wr_match ? wr_tag_i : tag_mem[rd_idx_i];
        fwd_state = state_mem[rd_idx_i];
        fwd_age   = age_mem[rd_idx_i];
        if (clr_i) begin
            // Clear hits every index
            fwd_state = init_state;
            fwd_age   = init_age;
        end else if (wr_match) begin
            fwd_state = wr_state_i;
            fwd_age   = wr_age_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_tag_o   <= fwd_tag;
            rd_state_o <= fwd_state;
            rd_age_o   <= fwd_age;
        end
    end

endmodule : cache_array

`default_nettype wire

/* src/way_select.sv */
// Hit detection and victim choice across the ways of one set
`timescale 1ns/1ps
`default_nettype none

module way_select #(
    parameter int WAYS = 8
) (
    input  wire  cache_line_pkg::tag_t              tag_i,
    input  wire  cache_line_pkg::tag_t  [WAYS-1:0]  set_tag_i,
    input  wire  cache_line_pkg::mesi_e [WAYS-1:0]  set_state_i,
    input  wire  cache_line_pkg::age_t  [WAYS-1:0]  set_age_i,
    output logic                                    hit_o,
    output logic [$clog2(WAYS)-1:0]                 hit_way_o,
    output logic [$clog2(WAYS)-1:0]                 victim_way_o
);
    import cache_line_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);

    // Per-way match vector, one bit per way
    logic [WAYS-1:0] match;

    // Invalid ways are preferred over eviction
    logic                any_invalid;
    logic [WAY_BITS-1:0] invalid_way;
    logic [WAY_BITS-1:0] oldest_way;

    // Tag compare, an invalid line never hits
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = (set_tag_i[w] == tag_i) && (set_state_i[w] != ST_I);
        end
    end

    // At most one way holds a given tag
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (match[w]) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_BITS'(w);
            end
        end
    end

    // Walk downward so the lowest invalid way is kept
    always_comb begin
        any_invalid = 1'b0;
        invalid_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (set_state_i[w] == ST_I) begin
                any_invalid = 1'b1;
                invalid_way = WAY_BITS'(w);
            end
        end
    end

    // Ages form a permutation, so exactly one way is the oldest
    always_comb begin
        oldest_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (set_age_i[w] == age_t'(WAYS - 1)) begin
                oldest_way = WAY_BITS'(w);
            end
        end
    end

    // Victim used by the fill on a miss
    assign victim_way_o = any_invalid ? invalid_way : oldest_way;

endmodule : way_select

`default_nettype wire

/* src/line_update.sv */
// Next MESI state, LRU aging and result flags for one command on one set
`timescale 1ns/1ps
`default_nettype none

module line_update #(
    parameter int WAYS = 8
) (
    input  wire  cache_cmd_pkg::cache_op_e          op_i,
    input  wire  cache_line_pkg::tag_t              tag_i,
    input  wire                                     shared_i,
    input  wire                                     hit_i,
    input  wire  [$clog2(WAYS)-1:0]                 hit_way_i,
    input  wire  [$clog2(WAYS)-1:0]                 victim_way_i,
    input  wire  cache_line_pkg::tag_t  [WAYS-1:0]  set_tag_i,
    input  wire  cache_line_pkg::mesi_e [WAYS-1:0]  set_state_i,
    input  wire  cache_line_pkg::age_t  [WAYS-1:0]  set_age_i,
    output cache_line_pkg::tag_t  [WAYS-1:0]        new_tag_o,
    output cache_line_pkg::mesi_e [WAYS-1:0]        new_state_o,
    output cache_line_pkg::age_t  [WAYS-1:0]        new_age_o,
    output logic [$clog2(WAYS)-1:0]                 way_o,
    output cache_line_pkg::mesi_e                   state_o,
    output logic                                    writeback_o
);
    import cache_cmd_pkg::*;
    import cache_line_pkg::*;

    // Accessed way and whether it moves to the front of the LRU order
    logic [$clog2(WAYS)-1:0] sel_way;
    logic                    touch;
    age_t                    old_age;

    always_comb begin
        new_tag_o   = set_tag_i;
        new_state_o = set_state_i;
        sel_way     = '0;
        touch       = 1'b0;
        writeback_o = 1'b0;
        case (op_i)
            OP_DREAD, OP_IFETCH, OP_DWRITE: begin
                touch = 1'b1;
                if (hit_i) begin
                    sel_way = hit_way_i;
                    // Reads keep the state and a write dirties the line
                    if (op_i == OP_DWRITE) begin
                        new_state_o[hit_way_i] = ST_M;
                    end
                end else begin
                    sel_way = victim_way_i;
                    // Evicting a dirty line needs a write-back
                    writeback_o = (set_state_i[victim_way_i] == ST_M);
                    new_tag_o[victim_way_i] = tag_i;
                    if (op_i == OP_DWRITE) begin
                        new_state_o[victim_way_i] = ST_M;
                    end else if (shared_i) begin
                        new_state_o[victim_way_i] = ST_S;
                    end else begin
                        new_state_o[victim_way_i] = ST_E;
                    end
                end
            end
            OP_INVAL: begin
                if (hit_i) begin
                    sel_way = hit_way_i;
                    new_state_o[hit_way_i] = ST_I;
                end
            end
            OP_SNOOP: begin
                if (hit_i) begin
                    sel_way = hit_way_i;
                    // Owner supplies its dirty copy and drops to S
                    writeback_o = (set_state_i[hit_way_i] == ST_M);
                    new_state_o[hit_way_i] = ST_S;
                end
            end
            OP_CLEAR: begin
                for (int w = 0; w < WAYS; w++) begin
                    new_state_o[w] = ST_I;
                end
            end
            default: begin
                // Unknown opcodes leave the set alone
            end
        endcase
    end

    // Ways younger than the accessed one age by one
    assign old_age = set_age_i[sel_way];

    always_comb begin
        new_age_o = set_age_i;
        if (op_i == OP_CLEAR) begin
            for (int w = 0; w < WAYS; w++) begin
                new_age_o[w] = age_t'(w);
            end
        end else if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (set_age_i[w] < old_age) begin
                    new_age_o[w] = set_age_i[w] + 1'b1;
                end
            end
            new_age_o[sel_way] = '0;
        end
    end

    assign way_o   = sel_way;
    assign state_o = new_state_o[sel_way];

endmodule : line_update

`default_nettype wire

/* src/split_cache_top.sv */
// Command stage, data and instruction side routing, result registers and counters
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module split_cache_top (
    input  wire                                  clk,
    input  wire                                  rst_n_i,
    input  wire                                  cmd_valid_i,
    input  wire  cache_cmd_pkg::cache_op_e       cmd_op_i,
    input  wire  [31:0]                          cmd_addr_i,
    input  wire                                  cmd_shared_i,
    output logic                                 done_o,
    output logic                                 hit_o,
    output logic [$clog2(`D_WAYS)-1:0]           way_o,
    output cache_line_pkg::mesi_e                state_o,
    output logic                                 writeback_o,
    output logic [`CNT_BITS-1:0]                 hit_count_o,
    output logic [`CNT_BITS-1:0]                 miss_count_o
);
    import cache_cmd_pkg::*;
    import cache_line_pkg::*;

    localparam int WAY_W = $clog2(`D_WAYS);
    localparam int I_W   = $clog2(`I_WAYS);

    // Address fields of the incoming command
    logic [`SET_BITS-1:0] cmd_idx;
    tag_t                 cmd_tag;
    logic                 d_rd_en;
    logic                 i_rd_en;

    // Stage 1 command, only the valid bit is control state
    logic                 s1_valid;
    cache_op_e            s1_op;
    logic [`SET_BITS-1:0] s1_idx;
    tag_t                 s1_tag;
    logic                 s1_shared;

    // Stage 1 decode
    logic                 d_wr_en;
    logic                 i_wr_en;
    logic                 clr;
    logic                 counted;

    // Data side set and results
    tag_t  [`D_WAYS-1:0]  d_set_tag, d_new_tag;
    mesi_e [`D_WAYS-1:0]  d_set_state, d_new_state;
    age_t  [`D_WAYS-1:0]  d_set_age, d_new_age;
    logic                 d_hit, d_wb;
    logic  [WAY_W-1:0]    d_hit_way, d_victim, d_way;
    mesi_e                d_state;

    // Instruction side set and results
    tag_t  [`I_WAYS-1:0]  i_set_tag, i_new_tag;
    mesi_e [`I_WAYS-1:0]  i_set_state, i_new_state;
    age_t  [`I_WAYS-1:0]  i_set_age, i_new_age;
    logic                 i_hit, i_wb;
    logic  [I_W-1:0]      i_hit_way, i_victim, i_way;
    mesi_e                i_state;

    // Result of the side the command was routed to
    logic                 res_hit;

    assign cmd_idx = cmd_addr_i[`OFFSET_BITS +: `SET_BITS];
    assign cmd_tag = cmd_addr_i[31 -: `TAG_BITS];

    // Fetches read the I side, clear touches both, the rest go to D
    assign d_rd_en = cmd_valid_i && (cmd_op_i != OP_IFETCH);
    assign i_rd_en = cmd_valid_i && ((cmd_op_i == OP_IFETCH) || (cmd_op_i == OP_CLEAR));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            s1_op     <= cmd_op_i;
            s1_idx    <= cmd_idx;
            s1_tag    <= cmd_tag;
            s1_shared <= cmd_shared_i;
        end
    end

    assign d_wr_en = s1_valid && (s1_op inside {OP_DREAD, OP_DWRITE, OP_INVAL, OP_SNOOP});
    assign i_wr_en = s1_valid && (s1_op == OP_IFETCH);
    assign clr     = s1_valid && (s1_op == OP_CLEAR);
    assign counted = s1_valid && (s1_op inside {OP_DREAD, OP_DWRITE, OP_IFETCH});

    cache_array #(.WAYS(`D_WAYS)) i_d_array (
        .clk(clk), .rst_n_i(rst_n_i), .rd_en_i(d_rd_en), .rd_idx_i(cmd_idx),
        .wr_en_i(d_wr_en), .wr_idx_i(s1_idx), .wr_tag_i(d_new_tag),
        .wr_state_i(d_new_state), .wr_age_i(d_new_age), .clr_i(clr),
        .rd_tag_o(d_set_tag), .rd_state_o(d_set_state), .rd_age_o(d_set_age)
    );

    way_select #(.WAYS(`D_WAYS)) i_d_sel (
        .tag_i(s1_tag), .set_tag_i(d_set_tag), .set_state_i(d_set_state),
        .set_age_i(d_set_age), .hit_o(d_hit), .hit_way_o(d_hit_way), .victim_way_o(d_victim)
    );

    line_update #(.WAYS(`D_WAYS)) i_d_upd (
        .op_i(s1_op), .tag_i(s1_tag), .shared_i(s1_shared), .hit_i(d_hit),
        .hit_way_i(d_hit_way), .victim_way_i(d_victim), .set_tag_i(d_set_tag),
        .set_state_i(d_set_state), .set_age_i(d_set_age), .new_tag_o(d_new_tag),
        .new_state_o(d_new_state), .new_age_o(d_new_age), .way_o(d_way),
        .state_o(d_state), .writeback_o(d_wb)
    );

    cache_array #(.WAYS(`I_WAYS)) i_i_array (
        .clk(clk), .rst_n_i(rst_n_i), .rd_en_i(i_rd_en), .rd_idx_i(cmd_idx),
        .wr_en_i(i_wr_en), .wr_idx_i(s1_idx), .wr_tag_i(i_new_tag),
        .wr_state_i(i_new_state), .wr_age_i(i_new_age), .clr_i(clr),
        .rd_tag_o(i_set_tag), .rd_state_o(i_set_state), .rd_age_o(i_set_age)
    );

    way_select #(.WAYS(`I_WAYS)) i_i_sel (
        .tag_i(s1_tag), .set_tag_i(i_set_tag), .set_state_i(i_set_state),
        .set_age_i(i_set_age), .hit_o(i_hit), .hit_way_o(i_hit_way), .victim_way_o(i_victim)
    );

    line_update #(.WAYS(`I_WAYS)) i_i_upd (
        .op_i(s1_op), .tag_i(s1_tag), .shared_i(s1_shared), .hit_i(i_hit),
        .hit_way_i(i_hit_way), .victim_way_i(i_victim), .set_tag_i(i_set_tag),
        .set_state_i(i_set_state), .set_age_i(i_set_age), .new_tag_o(i_new_tag),
        .new_state_o(i_new_state), .new_age_o(i_new_age), .way_o(i_way),
        .state_o(i_state), .writeback_o(i_wb)
    );

    // Clear reports no hit even if a tag happened to match
    assign res_hit = (s1_op == OP_IFETCH) ? i_hit : (d_hit && (s1_op != OP_CLEAR));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_o       <= 1'b0;
            hit_o        <= 1'b0;
            writeback_o  <= 1'b0;
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            done_o      <= s1_valid;
            hit_o       <= s1_valid && res_hit;
            writeback_o <= s1_valid && ((s1_op == OP_IFETCH) ? i_wb : d_wb);
            // Only core accesses count
            if (counted && res_hit) begin
                hit_count_o <= hit_count_o + 1'b1;
            end
            if (counted && !res_hit) begin
                miss_count_o <= miss_count_o + 1'b1;
            end
        end
    end

    // Way and state are payload, qualified by done_o
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            way_o   <= (s1_op == OP_IFETCH) ? WAY_W'(i_way) : d_way;
            state_o <= (s1_op == OP_IFETCH) ? i_state : d_state;
        end
    end

endmodule : split_cache_top

`default_nettype wire

/* testbench/tb_split_cache.sv */
// Split cache testbench with clock, reset, directed and random commands, model and compare
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_split_cache;
    import cache_cmd_pkg::*;
    import cache_line_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_DIRECTED = 26;
    localparam int N_RANDOM   = 400;
    localparam int N_CMDS     = N_DIRECTED + N_RANDOM;
    localparam int SETS       = 1 << `SET_BITS;
    localparam int WAY_W      = $clog2(`D_WAYS);

    // Expected response of one command
    typedef struct packed {
        logic                 hit;
        logic [WAY_W-1:0]     way;
        mesi_e                state;
        logic                 wb;
        logic [`CNT_BITS-1:0] hits;
        logic [`CNT_BITS-1:0] misses;
    } exp_t;

    logic                 clk;
    logic                 rst_n_i;
    logic                 cmd_valid_i;
    cache_op_e            cmd_op_i;
    logic [31:0]          cmd_addr_i;
    logic                 cmd_shared_i;
    logic                 done_o;
    logic                 hit_o;
    logic [WAY_W-1:0]     way_o;
    mesi_e                state_o;
    logic                 writeback_o;
    logic [`CNT_BITS-1:0] hit_count_o;
    logic [`CNT_BITS-1:0] miss_count_o;

    // Side 0 of the model is the data cache and side 1 the instruction cache
    logic [`TAG_BITS-1:0] m_tag   [2][SETS][`D_WAYS];
    mesi_e                m_state [2][SETS][`D_WAYS];
    int                   m_age   [2][SETS][`D_WAYS];
    int                   m_hits;
    int                   m_misses;
    exp_t                 exp_q[$];
    // Issue time of each outstanding command
    time                  issue_q[$];
    int                   errors;
    integer               seed;

    split_cache_top i_dut (
        .clk(clk), .rst_n_i(rst_n_i), .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
        .cmd_addr_i(cmd_addr_i), .cmd_shared_i(cmd_shared_i), .done_o(done_o),
        .hit_o(hit_o), .way_o(way_o), .state_o(state_o), .writeback_o(writeback_o),
        .hit_count_o(hit_count_o), .miss_count_o(miss_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every line invalid with age equal to its way number
    function automatic void model_reset();
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < SETS; i++) begin
                for (int w = 0; w < `D_WAYS; w++) begin
                    m_tag[s][i][w]   = '0;
                    m_state[s][i][w] = ST_I;
                    m_age[s][i][w]   = w;
                end
            end
        end
    endfunction

    // Applies one command to the model and queues the expected response
    function automatic void cache_model(input cache_op_e op, input logic [31:0] addr,
                                        input logic shared);
        int                   side;
        int                   nways;
        int                   idx;
        int                   hw;
        int                   vw;
        int                   sel;
        int                   old_age;
        logic                 hit;
        logic                 wb;
        logic [`TAG_BITS-1:0] tag;
        exp_t                 e;
        side  = (op == OP_IFETCH) ? 1 : 0;
        nways = (op == OP_IFETCH) ? `I_WAYS : `D_WAYS;
        idx   = int'(addr[`OFFSET_BITS +: `SET_BITS]);
        tag   = addr[31 -: `TAG_BITS];
        hit   = 1'b0;
        wb    = 1'b0;
        hw    = 0;
        vw    = -1;
        sel   = 0;
        if (op == OP_CLEAR) begin
            model_reset();
        end else begin
            for (int w = 0; w < nways; w++) begin
                if (m_state[side][idx][w] != ST_I && m_tag[side][idx][w] == tag) begin
                    hit = 1'b1;
                    hw  = w;
                end
                // First invalid way seen is the lowest one
                if (vw < 0 && m_state[side][idx][w] == ST_I) begin
                    vw = w;
                end
            end
            // Without a free way the least recently used one is evicted
            if (vw < 0) begin
                for (int w = 0; w < nways; w++) begin
                    if (m_age[side][idx][w] == nways - 1) begin
                        vw = w;
                    end
                end
            end
            case (op)
                OP_DREAD, OP_DWRITE, OP_IFETCH: begin
                    sel = hit ? hw : vw;
                    if (hit) begin
                        m_hits++;
                        if (op == OP_DWRITE) begin
                            m_state[side][idx][sel] = ST_M;
                        end
                    end else begin
                        m_misses++;
                        wb = (m_state[side][idx][sel] == ST_M);
                        m_tag[side][idx][sel]   = tag;
                        m_state[side][idx][sel] = (op == OP_DWRITE) ? ST_M :
                                                  (shared ? ST_S : ST_E);
                    end
                    // Younger ways age by one and the accessed way becomes the newest
                    old_age = m_age[side][idx][sel];
                    for (int w = 0; w < nways; w++) begin
                        if (m_age[side][idx][w] < old_age) begin
                            m_age[side][idx][w]++;
                        end
                    end
                    m_age[side][idx][sel] = 0;
                end
                OP_INVAL: begin
                    if (hit) begin
                        sel = hw;
                        m_state[side][idx][sel] = ST_I;
                    end
                end
                OP_SNOOP: begin
                    if (hit) begin
                        sel = hw;
                        wb  = (m_state[side][idx][sel] == ST_M);
                        m_state[side][idx][sel] = ST_S;
                    end
                end
                default: begin
                end
            endcase
        end
        e.hit    = hit;
        e.way    = sel[WAY_W-1:0];
        e.state  = m_state[side][idx][sel];
        e.wb     = wb;
        e.hits   = m_hits[`CNT_BITS-1:0];
        e.misses = m_misses[`CNT_BITS-1:0];
        exp_q.push_back(e);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set);
        return {`TAG_BITS'(tag), `SET_BITS'(set), `OFFSET_BITS'(0)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // One command per falling edge and the model sees it in issue order
    task automatic issue_cmd(input cache_op_e op, input logic [31:0] addr, input logic shared);
        @(negedge clk);
        cmd_valid_i  = 1'b1;
        cmd_op_i     = op;
        cmd_addr_i   = addr;
        cmd_shared_i = shared;
        cache_model(op, addr, shared);
        issue_q.push_back($time);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            cmd_valid_i = 1'b0;
        end
    endtask

    // Back to back commands on 4 sets and 12 tags with a rare clear
    task automatic random_cmds(input int n);
        logic [31:0] rnd;
        cache_op_e   op;
        int          tag_sel;
        for (int k = 0; k < n; k++) begin
            rnd     = $random(seed);
            tag_sel = int'(rnd[7:0]) % 12;
            case (rnd[18:16])
                3'd2, 3'd3: op = OP_DWRITE;
                3'd4:       op = OP_IFETCH;
                3'd5:       op = OP_INVAL;
                3'd6:       op = OP_SNOOP;
                default:    op = OP_DREAD;
            endcase
            if (rnd[31:26] == 6'd0) begin
                op = OP_CLEAR;
            end
            issue_cmd(op, {`TAG_BITS'(32'h300 + tag_sel), 2'b00, rnd[9:8], rnd[15:10]},
                      rnd[20]);
        end
    endtask

    // Outputs are compared at the falling edge where they are stable
    initial begin
        exp_t e;
        time  t_issue;
        forever begin
            @(negedge clk);
            if (done_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t ns: done_o pulsed with no command outstanding",
                             $time);
                end else begin
                    e       = exp_q.pop_front();
                    t_issue = issue_q.pop_front();
                    // Result is due two cycles after the command was presented
                    check_value("done_o delay", 32'(($time - t_issue) / CLK_PERIOD), 32'd2);
                    check_value("hit_o", 32'(hit_o), 32'(e.hit));
                    check_value("way_o", 32'(way_o), 32'(e.way));
                    check_value("state_o", 32'(state_o), 32'(e.state));
                    check_value("writeback_o", 32'(writeback_o), 32'(e.wb));
                    check_value("hit_count_o", 32'(hit_count_o), 32'(e.hits));
                    check_value("miss_count_o", 32'(miss_count_o), 32'(e.misses));
                end
            end
        end
    end

    // Watchdog sized from the command count plus margin for reset and drain
    initial begin
        #((N_CMDS + 50) * CLK_PERIOD);
        $display("Timeout: run did not finish, errors so far: %0d", errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int t;
        errors       = 0;
        seed         = 32'h80b1_b497;
        m_hits       = 0;
        m_misses     = 0;
        rst_n_i      = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_op_i     = OP_DREAD;
        cmd_addr_i   = '0;
        cmd_shared_i = 1'b0;
        model_reset();
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        // Cold misses fill way 0 in E or S and repeats hit unchanged
        issue_cmd(OP_DREAD, make_addr(32'h10, 1), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h10, 1), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h11, 2), 1'b1);
        issue_cmd(OP_DREAD, make_addr(32'h11, 2), 1'b1);
        // Write to M, snoop back to S with write-back, invalidate, then miss again
        issue_cmd(OP_DWRITE, make_addr(32'h10, 1), 1'b0);
        issue_cmd(OP_SNOOP, make_addr(32'h10, 1), 1'b0);
        issue_cmd(OP_INVAL, make_addr(32'h10, 1), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h10, 1), 1'b0);
        // Fill all 8 ways of set 3 with the odd tags dirty
        for (t = 0; t < 8; t++) begin
            issue_cmd(t[0] ? OP_DWRITE : OP_DREAD, make_addr(32'h200 + t, 3), 1'b0);
        end
        // Touching way 0 makes the next evictions take way 1 (M) and way 2 (E)
        issue_cmd(OP_DREAD, make_addr(32'h200, 3), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h208, 3), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h209, 3), 1'b0);
        // Fetches fill the I side only
        issue_cmd(OP_IFETCH, make_addr(32'h40, 5), 1'b0);
        issue_cmd(OP_IFETCH, make_addr(32'h40, 5), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h40, 5), 1'b0);
        idle_cycles(1);
        random_cmds(N_RANDOM);
        // Reads right behind a clear fill way 0
        issue_cmd(OP_CLEAR, make_addr(0, 0), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h10, 1), 1'b0);
        issue_cmd(OP_DREAD, make_addr(32'h205, 3), 1'b0);
        issue_cmd(OP_IFETCH, make_addr(32'h40, 5), 1'b0);
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(4);
        $display("Errors: %0d in %0d commands", errors, N_CMDS);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_split_cache

`default_nettype wire

/* list.f */
+incdir+include
src/cache_cmd_pkg.sv
src/cache_line_pkg.sv
src/cache_array.sv
src/way_select.sv
src/line_update.sv
src/split_cache_top.sv
testbench/tb_split_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; success only when the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -f list.f --top-module tb_split_cache -Mdir obj_dir -o sim_split_cache &&
    ./obj_dir/sim_split_cache | tee /dev/stderr | grep -qx '\*\*\* PASSED \*\*\*' ||
    exit 1
exit 0
